// File: adam_cfg_pkg.sv
`default_nettype none

package adam_cfg_pkg;

    // memory blocks that share one soft reset and one pause handshake
    localparam int NO_MEMS = 2;

    // gpio pins routed through the pad multiplexer
    localparam int NO_PINS = 8;

    // width of one pin's function select
    localparam int FUNC_WIDTH = 2;

    // soft reset is held for this many clock cycles
    localparam int SRST_CYCLES = 16;

    // must be able to hold SRST_CYCLES
    localparam int CNT_WIDTH = 5;

endpackage

`default_nettype wire

// File: adam_pad_pkg.sv
`default_nettype none

package adam_pad_pkg;

    // pin function select, one per gpio pin
    typedef enum logic [adam_cfg_pkg::FUNC_WIDTH-1:0] {
        // pin follows the gpio registers
        FUNC_GPIO = 2'd0,
        // push-pull peripheral output
        FUNC_ALT0 = 2'd1,
        // open-drain peripheral output
        FUNC_ALT1 = 2'd2,
        // pad parked as input with output low
        FUNC_OFF  = 2'd3
    } func_e;

    // pad direction
    localparam logic MODE_IN  = 1'b0;
    localparam logic MODE_OUT = 1'b1;

    // pad output driver type
    localparam logic OTYPE_PP = 1'b0;
    localparam logic OTYPE_OD = 1'b1;

endpackage

`default_nettype wire

// File: adam_io_if.sv
`timescale 1ns/100ps
`default_nettype none

interface adam_io_if;
    import adam_cfg_pkg::*;

    // one bit per pin in every field
    logic [NO_PINS-1:0] i;
    logic [NO_PINS-1:0] o;
    logic [NO_PINS-1:0] mode;
    logic [NO_PINS-1:0] otype;

    // driver side owned by the pad multiplexer
    modport master (
        input  i,
        output o,
        output mode,
        output otype
    );

    // pad ring side
    modport pad (
        output i,
        input  o,
        input  mode,
        input  otype
    );

endinterface

`default_nettype wire

// File: adam_hold_timer.sv
`timescale 1ns/100ps
`default_nettype none

module adam_hold_timer (
    input  logic clk,
    input  logic rst_n_i,

    input  logic load_i,
    output logic done_o
);
    import adam_cfg_pkg::*;

    logic [CNT_WIDTH-1:0] cnt_q;

    // starts loaded so the power-on hold needs no load pulse
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= CNT_WIDTH'(SRST_CYCLES);
        end else if (load_i) begin
            cnt_q <= CNT_WIDTH'(SRST_CYCLES);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign done_o = (cnt_q == '0);

    // the sequencer only reloads once the previous hold has run out
    a_load_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        load_i |-> (cnt_q == '0)
    ) else $error("hold timer reloaded while still counting");

endmodule

`default_nettype wire

// File: adam_pause_seq.sv
`timescale 1ns/100ps
`default_nettype none

module adam_pause_seq (
    input  logic                             clk,
    input  logic                             rst_n_i,

    input  logic                             pause_req_i,
    input  logic                             srst_req_i,
    input  logic [adam_cfg_pkg::NO_MEMS-1:0] mem_pause_ack_i,
    input  logic                             timer_done_i,

    output logic                             pause_ack_o,
    output logic [adam_cfg_pkg::NO_MEMS-1:0] mem_pause_req_o,
    output logic [adam_cfg_pkg::NO_MEMS-1:0] mem_srst_o,
    output logic                             timer_load_o,
    output logic                             freeze_o
);
    import adam_cfg_pkg::*;

    typedef enum logic [2:0] {
        HOLD,
        RUN,
        PAUSING,
        PAUSED,
        RESUMING
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   all_ack;
    logic   any_ack;

    assign all_ack = &mem_pause_ack_i;
    assign any_ack = |mem_pause_ack_i;

    always_comb begin
        state_d      = state_q;
        timer_load_o = 1'b0;

        case (state_q)
            HOLD: begin
                if (timer_done_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // soft reset wins over a pause request in the same cycle
                if (srst_req_i) begin
                    state_d      = HOLD;
                    timer_load_o = 1'b1;
                end else if (pause_req_i) begin
                    state_d = PAUSING;
                end
            end
            PAUSING: begin
                if (!pause_req_i) begin
                    state_d = RESUMING;
                end else if (all_ack) begin
                    state_d = PAUSED;
                end
            end
            PAUSED: begin
                if (!pause_req_i) begin
                    state_d = RESUMING;
                end
            end
            RESUMING: begin
                // memories must all drop their acks before a new pause
                if (!any_ack) begin
                    state_d = RUN;
                end
            end
            default: begin
                state_d = HOLD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= HOLD;
        end else begin
            state_q <= state_d;
        end
    end

    // the last hold cycle is the one where the timer reports done
    assign mem_srst_o      = {NO_MEMS{(state_q == HOLD) && !timer_done_i}};
    assign mem_pause_req_o = {NO_MEMS{(state_q == PAUSING) || (state_q == PAUSED)}};
    assign pause_ack_o     = (state_q == PAUSED);
    assign freeze_o        = (state_q == PAUSED);

    a_pause_from_idle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(|mem_pause_req_o) |-> !$past(any_ack)
    ) else $error("pause request raised while a memory still acks");

    a_ack_after_all: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pause_ack_o |-> $past(all_ack)
    ) else $error("pause ack without all memory acks");

endmodule

`default_nettype wire

// File: adam_gpio_mux.sv
`timescale 1ns/100ps
`default_nettype none

module adam_gpio_mux (
    input  logic                                                 clk,
    input  logic                                                 rst_n_i,

    input  logic                                                 freeze_i,

    input  adam_pad_pkg::func_e [adam_cfg_pkg::NO_PINS-1:0]     gpio_func_i,
    input  logic                [adam_cfg_pkg::NO_PINS-1:0]     gpio_o_i,
    input  logic                [adam_cfg_pkg::NO_PINS-1:0]     gpio_mode_i,
    input  logic                [adam_cfg_pkg::NO_PINS-1:0]     gpio_otype_i,
    input  logic                [adam_cfg_pkg::NO_PINS-1:0]     alt0_o_i,
    input  logic                [adam_cfg_pkg::NO_PINS-1:0]     alt1_o_i,

    adam_io_if.master                                            pad,

    output logic                [adam_cfg_pkg::NO_PINS-1:0]     gpio_in_o
);
    import adam_cfg_pkg::*;
    import adam_pad_pkg::*;

    logic [NO_PINS-1:0] o_d;
    logic [NO_PINS-1:0] mode_d;
    logic [NO_PINS-1:0] otype_d;

    logic [NO_PINS-1:0] o_q;
    logic [NO_PINS-1:0] mode_q;
    logic [NO_PINS-1:0] otype_q;

    logic [NO_PINS-1:0] in_meta_q;
    logic [NO_PINS-1:0] in_sync_q;

    always_comb begin
        for (int p = 0; p < NO_PINS; p++) begin
            case (gpio_func_i[p])
                FUNC_GPIO: begin
                    o_d[p]     = gpio_o_i[p];
                    mode_d[p]  = gpio_mode_i[p];
                    otype_d[p] = gpio_otype_i[p];
                end
                FUNC_ALT0: begin
                    o_d[p]     = alt0_o_i[p];
                    mode_d[p]  = MODE_OUT;
                    otype_d[p] = OTYPE_PP;
                end
                FUNC_ALT1: begin
                    o_d[p]     = alt1_o_i[p];
                    mode_d[p]  = MODE_OUT;
                    otype_d[p] = OTYPE_OD;
                end
                default: begin
                    o_d[p]     = 1'b0;
                    mode_d[p]  = MODE_IN;
                    otype_d[p] = OTYPE_PP;
                end
            endcase
        end
    end

    // pads keep their last drive while the system is paused
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            o_q     <= '0;
            mode_q  <= {NO_PINS{MODE_IN}};
            otype_q <= {NO_PINS{OTYPE_PP}};
        end else if (!freeze_i) begin
            o_q     <= o_d;
            mode_q  <= mode_d;
            otype_q <= otype_d;
        end
    end

    assign pad.o     = o_q;
    assign pad.mode  = mode_q;
    assign pad.otype = otype_q;

    // two-flop synchroniser that keeps sampling during a pause
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= pad.i;
            in_sync_q <= in_meta_q;
        end
    end

    assign gpio_in_o = in_sync_q;

endmodule

`default_nettype wire

// File: adam_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module adam_subsys (
    input  logic                                                clk,
    input  logic                                                rst_n_i,

    input  logic                                                pause_req_i,
    output logic                                                pause_ack_o,
    input  logic                                                srst_req_i,

    output logic [adam_cfg_pkg::NO_MEMS-1:0]                    mem_srst_o,
    output logic [adam_cfg_pkg::NO_MEMS-1:0]                    mem_pause_req_o,
    input  logic [adam_cfg_pkg::NO_MEMS-1:0]                    mem_pause_ack_i,

    input  logic [adam_cfg_pkg::NO_PINS*adam_cfg_pkg::FUNC_WIDTH-1:0] gpio_func_i,
    input  logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_o_i,
    input  logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_mode_i,
    input  logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_otype_i,
    input  logic [adam_cfg_pkg::NO_PINS-1:0]                    alt0_o_i,
    input  logic [adam_cfg_pkg::NO_PINS-1:0]                    alt1_o_i,
    output logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_in_o,

    input  logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_pad_i,
    output logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_pad_o,
    output logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_pad_mode_o,
    output logic [adam_cfg_pkg::NO_PINS-1:0]                    gpio_pad_otype_o
);
    import adam_cfg_pkg::*;
    import adam_pad_pkg::*;

    logic                timer_load;
    logic                timer_done;
    logic                freeze;
    func_e [NO_PINS-1:0] gpio_func;

    // function selects arrive packed with FUNC_WIDTH bits per pin
    for (genvar g = 0; g < NO_PINS; g++) begin : g_func
        assign gpio_func[g] = func_e'(gpio_func_i[g*FUNC_WIDTH +: FUNC_WIDTH]);
    end

    adam_pause_seq u_pause_seq (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pause_req_i     (pause_req_i),
        .srst_req_i      (srst_req_i),
        .mem_pause_ack_i (mem_pause_ack_i),
        .timer_done_i    (timer_done),
        .pause_ack_o     (pause_ack_o),
        .mem_pause_req_o (mem_pause_req_o),
        .mem_srst_o      (mem_srst_o),
        .timer_load_o    (timer_load),
        .freeze_o        (freeze)
    );

    adam_hold_timer u_hold_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (timer_load),
        .done_o  (timer_done)
    );

    adam_io_if u_gpio_io ();

    // pad ring side of the interface
    assign u_gpio_io.i      = gpio_pad_i;
    assign gpio_pad_o       = u_gpio_io.o;
    assign gpio_pad_mode_o  = u_gpio_io.mode;
    assign gpio_pad_otype_o = u_gpio_io.otype;

    adam_gpio_mux u_gpio_mux (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .freeze_i     (freeze),
        .gpio_func_i  (gpio_func),
        .gpio_o_i     (gpio_o_i),
        .gpio_mode_i  (gpio_mode_i),
        .gpio_otype_i (gpio_otype_i),
        .alt0_o_i     (alt0_o_i),
        .alt1_o_i     (alt1_o_i),
        .pad          (u_gpio_io.master),
        .gpio_in_o    (gpio_in_o)
    );

endmodule

`default_nettype wire

// File: tb_adam_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adam_subsys;
    import adam_cfg_pkg::*;
    import adam_pad_pkg::*;

    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_CYCLES   = 4000;
    localparam int          FUNC_BITS    = NO_PINS * FUNC_WIDTH;
    localparam int unsigned SEED         = 32'h217c6eb8;
    // full run at 4 ns per cycle plus slack
    localparam int          TIMEOUT_NS   = (RESET_CYCLES + NUM_CYCLES + 200) * 4;

    typedef enum int {
        M_HOLD,
        M_RUN,
        M_PAUSING,
        M_PAUSED,
        M_RESUMING
    } mstate_e;

    logic                 clk;
    logic                 rst_n;
    logic                 pause_req;
    logic                 srst_req;
    logic [NO_MEMS-1:0]   mem_ack;
    logic [FUNC_BITS-1:0] gpio_func;
    logic [NO_PINS-1:0]   gpio_o;
    logic [NO_PINS-1:0]   gpio_mode;
    logic [NO_PINS-1:0]   gpio_otype;
    logic [NO_PINS-1:0]   alt0_o;
    logic [NO_PINS-1:0]   alt1_o;
    logic [NO_PINS-1:0]   pad_in;

    logic                 pause_ack;
    logic [NO_MEMS-1:0]   mem_pause_req;
    logic [NO_MEMS-1:0]   mem_srst;
    logic [NO_PINS-1:0]   gpio_in;
    logic [NO_PINS-1:0]   pad_o;
    logic [NO_PINS-1:0]   pad_mode;
    logic [NO_PINS-1:0]   pad_otype;

    // reference model state
    mstate_e              m_state;
    int                   m_cnt;
    logic [NO_PINS-1:0]   m_o;
    logic [NO_PINS-1:0]   m_mode;
    logic [NO_PINS-1:0]   m_otype;
    logic [NO_PINS-1:0]   m_meta;
    logic [NO_PINS-1:0]   m_sync;

    int                   ack_dly [NO_MEMS];
    int                   pause_count;
    int                   srst_count;
    int                   srst_len;

    adam_subsys u_adam_subsys (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .pause_req_i      (pause_req),
        .pause_ack_o      (pause_ack),
        .srst_req_i       (srst_req),
        .mem_srst_o       (mem_srst),
        .mem_pause_req_o  (mem_pause_req),
        .mem_pause_ack_i  (mem_ack),
        .gpio_func_i      (gpio_func),
        .gpio_o_i         (gpio_o),
        .gpio_mode_i      (gpio_mode),
        .gpio_otype_i     (gpio_otype),
        .alt0_o_i         (alt0_o),
        .alt1_o_i         (alt1_o),
        .gpio_in_o        (gpio_in),
        .gpio_pad_i       (pad_in),
        .gpio_pad_o       (pad_o),
        .gpio_pad_mode_o  (pad_mode),
        .gpio_pad_otype_o (pad_otype)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [NO_PINS-1:0] exp_v,
                           input logic [NO_PINS-1:0] act_v);
        assert (act_v === exp_v) else begin
            stop_with_failure($sformatf("** Error: %s expected 0x%0h actual 0x%0h at %0t",
                                        name, exp_v, act_v, $time));
        end
    endtask

    // one clock edge of the sequencer, hold counter, pad registers and synchroniser
    task automatic model_step();
        mstate_e nxt;
        logic    freeze;
        func_e   sel;
        nxt    = m_state;
        freeze = (m_state == M_PAUSED);
        case (m_state)
            M_HOLD: begin
                if (m_cnt == 0) begin
                    nxt = M_RUN;
                end
            end
            M_RUN: begin
                if (srst_req) begin
                    nxt = M_HOLD;
                end else if (pause_req) begin
                    nxt = M_PAUSING;
                end
            end
            M_PAUSING: begin
                if (!pause_req) begin
                    nxt = M_RESUMING;
                end else if (&mem_ack) begin
                    nxt = M_PAUSED;
                end
            end
            M_PAUSED: begin
                if (!pause_req) begin
                    nxt = M_RESUMING;
                end
            end
            default: begin
                if (mem_ack == '0) begin
                    nxt = M_RUN;
                end
            end
        endcase
        if (m_state == M_RUN && srst_req) begin
            m_cnt = SRST_CYCLES;
        end else if (m_cnt != 0) begin
            m_cnt--;
        end
        if (nxt == M_PAUSED && m_state != M_PAUSED) begin
            pause_count++;
        end
        m_state = nxt;
        if (!freeze) begin
            for (int p = 0; p < NO_PINS; p++) begin
                sel = func_e'(gpio_func[p*FUNC_WIDTH +: FUNC_WIDTH]);
                case (sel)
                    FUNC_GPIO: begin
                        m_o[p]     = gpio_o[p];
                        m_mode[p]  = gpio_mode[p];
                        m_otype[p] = gpio_otype[p];
                    end
                    FUNC_ALT0: begin
                        m_o[p]     = alt0_o[p];
                        m_mode[p]  = MODE_OUT;
                        m_otype[p] = OTYPE_PP;
                    end
                    FUNC_ALT1: begin
                        m_o[p]     = alt1_o[p];
                        m_mode[p]  = MODE_OUT;
                        m_otype[p] = OTYPE_OD;
                    end
                    default: begin
                        m_o[p]     = 1'b0;
                        m_mode[p]  = MODE_IN;
                        m_otype[p] = OTYPE_PP;
                    end
                endcase
            end
        end
        m_sync = m_meta;
        m_meta = pad_in;
    endtask

    task automatic check_outputs();
        logic srst_exp;
        logic req_exp;
        srst_exp = (m_state == M_HOLD) && (m_cnt != 0);
        req_exp  = (m_state == M_PAUSING) || (m_state == M_PAUSED);
        compare("mem_srst_o", NO_PINS'({NO_MEMS{srst_exp}}), NO_PINS'(mem_srst));
        compare("mem_pause_req_o", NO_PINS'({NO_MEMS{req_exp}}), NO_PINS'(mem_pause_req));
        compare("pause_ack_o", NO_PINS'(m_state == M_PAUSED), NO_PINS'(pause_ack));
        compare("gpio_pad_o", m_o, pad_o);
        compare("gpio_pad_mode_o", m_mode, pad_mode);
        compare("gpio_pad_otype_o", m_otype, pad_otype);
        compare("gpio_in_o", m_sync, gpio_in);
        // every hold seen on the pins must last the full length
        if (mem_srst[0]) begin
            srst_len++;
        end else begin
            if (srst_len != 0) begin
                assert (srst_len == SRST_CYCLES) else begin
                    stop_with_failure($sformatf("soft reset hold lasted %0d cycles, not %0d",
                                                srst_len, SRST_CYCLES));
                end
                srst_count++;
            end
            srst_len = 0;
        end
    endtask

    // each memory answers a change of its request after 0 to 5 cycles
    task automatic mem_respond();
        logic want;
        want = (m_state == M_PAUSING) || (m_state == M_PAUSED);
        for (int m = 0; m < NO_MEMS; m++) begin
            if (mem_ack[m] != want) begin
                if (ack_dly[m] == 0) begin
                    mem_ack[m] = want;
                end else begin
                    ack_dly[m]--;
                end
            end else begin
                ack_dly[m] = int'($urandom % 6);
            end
        end
    endtask

    task automatic drive_inputs();
        if (pause_req) begin
            if ($urandom % 24 == 0) begin
                pause_req = 1'b0;
            end
        end else if ($urandom % 16 == 0) begin
            pause_req = 1'b1;
        end
        srst_req   = !srst_req && ($urandom % 32 == 0);
        gpio_func  = FUNC_BITS'($urandom);
        gpio_o     = NO_PINS'($urandom);
        gpio_mode  = NO_PINS'($urandom);
        gpio_otype = NO_PINS'($urandom);
        alt0_o     = NO_PINS'($urandom);
        alt1_o     = NO_PINS'($urandom);
        pad_in     = NO_PINS'($urandom);
        mem_respond();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("test timed out after %0d ns without finishing", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        void'($urandom(SEED));
        clk         = 1'b0;
        rst_n       = 1'b0;
        pause_req   = 1'b0;
        srst_req    = 1'b0;
        mem_ack     = '0;
        gpio_func   = '0;
        gpio_o      = '0;
        gpio_mode   = '0;
        gpio_otype  = '0;
        alt0_o      = '0;
        alt1_o      = '0;
        pad_in      = '0;
        m_state     = M_HOLD;
        m_cnt       = SRST_CYCLES;
        m_o         = '0;
        m_mode      = {NO_PINS{MODE_IN}};
        m_otype     = {NO_PINS{OTYPE_PP}};
        m_meta      = '0;
        m_sync      = '0;
        pause_count = 0;
        srst_count  = 0;
        srst_len    = 0;
        for (int m = 0; m < NO_MEMS; m++) begin
            ack_dly[m] = 0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check_outputs();

        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            model_step();
            #0.5;
            check_outputs();
            drive_inputs();
        end

        if (pause_count > 0 && srst_count > 1) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("run too short: %0d pauses, %0d soft reset holds",
                                        pause_count, srst_count));
        end
    end

endmodule

`default_nettype wire

// File: all.f
adam_cfg_pkg.sv
adam_pad_pkg.sv
adam_io_if.sv
adam_hold_timer.sv
adam_pause_seq.sv
adam_gpio_mux.sv
adam_subsys.sv
tb_adam_subsys.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := all.f
TOP        := tb_adam_subsys
RTL_TOP    := adam_subsys
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
